/* rtl/debugCommandParser.sv */
`timescale 1ns/1ps

module debugCommandParser #(
	parameter int numBanks = 4,
	parameter int wordsPerBank = 8
)
(
	input logic clk,
	input logic rstN,
	input logic [7:0] rxData,
	input logic rxEmpty,
	output logic rxRd,
	wbIf.master bus [numBanks],
	respIf.source resp
);

	localparam int numWords = numBanks * wordsPerBank;
	localparam logic [debugPkg::adrWidth-1:0] lastAdr = debugPkg::adrWidth'(numWords - 1);

	typedef enum logic [2:0]
	{
		sIdle,
		sFetchAdr,
		sFetchData,
		sBusCycle,
		sRespond,
		sDumpStep
	} stateT;

	stateT state;
	debugPkg::opcodeT opcode;
	logic [debugPkg::adrWidth-1:0] adr;
	logic [debugPkg::wordWidth-1:0] shiftReg;
	logic [1:0] byteCnt;
	logic busReq;
	logic busWe;
	logic respValid;
	debugPkg::respKindT respKind;
	logic [debugPkg::wordWidth-1:0] respData;
	logic [numBanks-1:0] ackVec;
	logic [debugPkg::wordWidth-1:0] datRVec [numBanks];
	logic [debugPkg::wordWidth-1:0] datRAny;
	logic ackAny;
	logic byteAvail;

	function automatic logic inRange(input logic [debugPkg::adrWidth-1:0] a);
		return int'(a) < numWords;
	endfunction

	function automatic logic [debugPkg::wordWidth-1:0] byteWord(input logic [7:0] b);
		return {{(debugPkg::wordWidth-8){1'b0}}, b};
	endfunction

	////////////////////////////////////////
	// Bus fan-out and reply merge
	////////////////////////////////////////

	for (genvar g = 0; g < numBanks; g++)
	begin : busLink
		assign bus[g].cyc = busReq;
		assign bus[g].stb = busReq;
		assign bus[g].we = busWe;
		assign bus[g].adr = adr;
		assign bus[g].datW = shiftReg;
		assign ackVec[g] = bus[g].ack;
		assign datRVec[g] = bus[g].datR;
	end

	// Unselected banks return zero
	always_comb
	begin
		datRAny = '0;
		for (int i = 0; i < numBanks; i++)
		begin
			datRAny = datRAny | datRVec[i];
		end
	end

	assign ackAny = |ackVec;

	assign resp.valid = respValid;
	assign resp.kind = respKind;
	assign resp.data = respData;

	// No byte while the previous pop is still in flight
	assign byteAvail = !rxEmpty && !rxRd;

	////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= sIdle;
			opcode <= debugPkg::opRead;
			adr <= '0;
			shiftReg <= '0;
			byteCnt <= '0;
			rxRd <= 1'b0;
			busReq <= 1'b0;
			busWe <= 1'b0;
			respValid <= 1'b0;
			respKind <= debugPkg::respByte;
			respData <= '0;
		end
		else
		begin
			rxRd <= 1'b0;
			case (state)
				sIdle:
				begin
					if (byteAvail)
					begin
						rxRd <= 1'b1;
						opcode <= debugPkg::opcodeT'(rxData);
						case (debugPkg::opcodeT'(rxData))
							debugPkg::opRead, debugPkg::opWrite:
								state <= sFetchAdr;
							debugPkg::opDump:
							begin
								// Walk from word zero
								adr <= '0;
								busReq <= 1'b1;
								busWe <= 1'b0;
								state <= sBusCycle;
							end
							default:
							begin
								respKind <= debugPkg::respByte;
								respData <= byteWord(debugPkg::errByte);
								respValid <= 1'b1;
								state <= sRespond;
							end
						endcase
					end
				end
				sFetchAdr:
				begin
					if (byteAvail)
					begin
						rxRd <= 1'b1;
						adr <= rxData;
						byteCnt <= '0;
						if (opcode == debugPkg::opWrite)
							state <= sFetchData;
						else if (inRange(rxData))
						begin
							busReq <= 1'b1;
							busWe <= 1'b0;
							state <= sBusCycle;
						end
						else
						begin
							respKind <= debugPkg::respByte;
							respData <= byteWord(debugPkg::errByte);
							respValid <= 1'b1;
							state <= sRespond;
						end
					end
				end
				sFetchData:
				begin
					if (byteAvail)
					begin
						rxRd <= 1'b1;
						shiftReg <= {shiftReg[debugPkg::wordWidth-9:0], rxData};
						byteCnt <= byteCnt + 2'd1;
						// Bad address still eats all four data bytes
						if (byteCnt == 2'd3)
						begin
							if (inRange(adr))
							begin
								busReq <= 1'b1;
								busWe <= 1'b1;
								state <= sBusCycle;
							end
							else
							begin
								respKind <= debugPkg::respByte;
								respData <= byteWord(debugPkg::errByte);
								respValid <= 1'b1;
								state <= sRespond;
							end
						end
					end
				end
				sBusCycle:
				begin
					if (ackAny)
					begin
						busReq <= 1'b0;
						respValid <= 1'b1;
						if (busWe)
						begin
							respKind <= debugPkg::respByte;
							respData <= byteWord(debugPkg::ackByte);
						end
						else
						begin
							respKind <= debugPkg::respWord;
							respData <= datRAny;
						end
						state <= (opcode == debugPkg::opDump) ? sDumpStep : sRespond;
					end
				end
				sRespond:
				begin
					if (resp.ready)
					begin
						respValid <= 1'b0;
						state <= sIdle;
					end
				end
				sDumpStep:
				begin
					// Next word only once this one is taken
					if (resp.ready)
					begin
						respValid <= 1'b0;
						if (adr == lastAdr)
							state <= sIdle;
						else
						begin
							adr <= adr + 1'b1;
							busReq <= 1'b1;
							busWe <= 1'b0;
							state <= sBusCycle;
						end
					end
				end
				default:
					state <= sIdle;
			endcase
		end
	end

endmodule

/* rtl/debugPkg.sv */
package debugPkg;

	////////////////////////////////////////
	// Host protocol
	////////////////////////////////////////

	// Command opcodes, one byte each
	typedef enum logic [7:0]
	{
		opRead  = 8'h01,
		opWrite = 8'h02,
		opDump  = 8'h03
	} opcodeT;

	// Word replies go out most significant byte first
	typedef enum logic
	{
		respWord = 1'b0,
		respByte = 1'b1
	} respKindT;

	localparam logic [7:0] ackByte = 8'h4B;
	localparam logic [7:0] errByte = 8'hEE;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	localparam int wordWidth = 32;
	// Same as the single address byte on the host side
	localparam int adrWidth = 8;

endpackage

/* rtl/debugUnit.sv */
`timescale 1ns/1ps

module debugUnit #(
	parameter int numBanks = 4,
	parameter int wordsPerBank = 8
)
(
	input logic clk,
	input logic rstN,
	input logic [7:0] rxData,
	input logic rxEmpty,
	output logic rxRd,
	output logic [7:0] txData,
	input logic txFull,
	output logic txWr
);

	// One bus element per bank
	wbIf bus [numBanks] ();
	respIf respLink ();

	debugCommandParser #(
		.numBanks(numBanks),
		.wordsPerBank(wordsPerBank)
	) parser_i (
		.clk(clk),
		.rstN(rstN),
		.rxData(rxData),
		.rxEmpty(rxEmpty),
		.rxRd(rxRd),
		.bus(bus),
		.resp(respLink)
	);

	////////////////////////////////////////
	// State banks
	////////////////////////////////////////

	for (genvar g = 0; g < numBanks; g++)
	begin : bankGen
		stateBank #(
			.bankIndex(g),
			.wordsPerBank(wordsPerBank)
		) bank_i (
			.clk(clk),
			.rstN(rstN),
			.bus(bus[g])
		);
	end

	responseSerializer serializer_i (
		.clk(clk),
		.rstN(rstN),
		.resp(respLink),
		.txData(txData),
		.txFull(txFull),
		.txWr(txWr)
	);

endmodule

/* rtl/respIf.sv */
`timescale 1ns/1ps

interface respIf;

	logic valid;
	logic ready;
	debugPkg::respKindT kind;
	logic [debugPkg::wordWidth-1:0] data;

	modport source
	(
		output valid, kind, data,
		input ready
	);

	modport sink
	(
		input valid, kind, data,
		output ready
	);

endinterface

/* rtl/responseSerializer.sv */
`timescale 1ns/1ps

module responseSerializer
(
	input logic clk,
	input logic rstN,
	respIf.sink resp,
	output logic [7:0] txData,
	input logic txFull,
	output logic txWr
);

	logic [debugPkg::wordWidth-1:0] shiftReg;
	logic [2:0] bytesLeft;

	// Idle means nothing left to send
	assign resp.ready = (bytesLeft == 3'd0);

	// Top byte always goes next
	assign txData = shiftReg[debugPkg::wordWidth-1 -: 8];
	assign txWr = (bytesLeft != 3'd0) && !txFull;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			shiftReg <= '0;
			bytesLeft <= 3'd0;
		end
		else if (resp.valid && resp.ready)
		begin
			if (resp.kind == debugPkg::respWord)
			begin
				shiftReg <= resp.data;
				bytesLeft <= 3'd4;
			end
			else
			begin
				// Single byte moved up into the send slot
				shiftReg <= {resp.data[7:0], {(debugPkg::wordWidth-8){1'b0}}};
				bytesLeft <= 3'd1;
			end
		end
		else if (txWr)
		begin
			shiftReg <= shiftReg << 8;
			bytesLeft <= bytesLeft - 3'd1;
		end
	end

endmodule

/* rtl/stateBank.sv */
`timescale 1ns/1ps

module stateBank #(
	parameter int bankIndex = 0,
	parameter int wordsPerBank = 8
)
(
	input logic clk,
	input logic rstN,
	wbIf.slave bus
);

	localparam int idxBits = $clog2(wordsPerBank);
	localparam int selBits = debugPkg::adrWidth - idxBits;
	localparam logic [selBits-1:0] bankSel = selBits'(bankIndex);

	logic [debugPkg::wordWidth-1:0] mem [wordsPerBank];
	logic [idxBits-1:0] wordIdx;
	logic selected;
	logic ack;
	logic [debugPkg::wordWidth-1:0] datR;

	// Upper address bits pick the bank, lower bits the word
	assign wordIdx = bus.adr[idxBits-1:0];
	assign selected = bus.cyc && bus.stb &&
		(bus.adr[debugPkg::adrWidth-1:idxBits] == bankSel);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			ack <= 1'b0;
			datR <= '0;
			for (int i = 0; i < wordsPerBank; i++)
			begin
				mem[i] <= '0;
			end
		end
		else
		begin
			// One ack per strobe, a cycle after it
			ack <= selected && !ack;
			if (selected && !ack)
			begin
				if (bus.we)
					mem[wordIdx] <= bus.datW;
				datR <= mem[wordIdx];
			end
			else
				datR <= '0;
		end
	end

	assign bus.ack = ack;
	assign bus.datR = datR;

endmodule

/* rtl/wbIf.sv */
`timescale 1ns/1ps

interface wbIf;

	logic cyc;
	logic stb;
	logic we;
	logic [debugPkg::adrWidth-1:0] adr;
	logic [debugPkg::wordWidth-1:0] datW;
	logic [debugPkg::wordWidth-1:0] datR;
	logic ack;

	// Parser side
	modport master
	(
		output cyc, stb, we, adr, datW,
		input datR, ack
	);

	// Bank side
	modport slave
	(
		input cyc, stb, we, adr, datW,
		output datR, ack
	);

endinterface

/* run.sh */
#!/usr/bin/env bash
# Build and run the debug bridge regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module debugUnitTb -o simDebugUnit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/simDebugUnit)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

/* src.f */
rtl/debugPkg.sv
rtl/wbIf.sv
rtl/respIf.sv
rtl/stateBank.sv
rtl/debugCommandParser.sv
rtl/responseSerializer.sv
rtl/debugUnit.sv
testbench/debugUnitTb.sv

/* testbench/debugUnitTb.sv */
`timescale 1ns/1ps

module debugUnitTb;

	localparam int numBanks = 4;
	localparam int wordsPerBank = 8;
	localparam int numWords = numBanks * wordsPerBank;
	localparam int writesA = 16;
	localparam int badCount = 8;
	localparam int unknownCount = 8;
	localparam int lateWrites = 8;
	localparam int numCommands = 1 + 2 * writesA + 2 * badCount + 2 * unknownCount
		+ lateWrites + 1;
	localparam int byteTimeout = 2000;

	typedef logic [debugPkg::wordWidth-1:0] wordT;

	logic clk;
	logic rstN;
	logic [7:0] rxData;
	logic rxEmpty;
	logic rxRd;
	logic [7:0] txData;
	logic txFull;
	logic txWr;

	logic [7:0] rxQ [$];
	logic [7:0] txQ [$];
	wordT model [numWords];
	bit pressure;
	int stretch;
	int valueErrs;
	int streamErrs;

	debugUnit #(
		.numBanks(numBanks),
		.wordsPerBank(wordsPerBank)
	) dut_i (
		.clk(clk),
		.rstN(rstN),
		.rxData(rxData),
		.rxEmpty(rxEmpty),
		.rxRd(rxRd),
		.txData(txData),
		.txFull(txFull),
		.txWr(txWr)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// FIFO models
	////////////////////////////////////////

	// Receive side, first word falls through
	always @(posedge clk)
	begin
		if (rxRd)
		begin
			if (rxQ.size() == 0)
			begin
				$display("Parser popped an empty receive FIFO");
				streamErrs++;
			end
			else
				void'(rxQ.pop_front());
		end
		rxEmpty <= (rxQ.size() == 0);
		rxData <= (rxQ.size() != 0) ? rxQ[0] : 8'h00;
	end

	// Transmit side with random long full stretches
	always @(posedge clk)
	begin
		if (txWr && !txFull)
			txQ.push_back(txData);
		if (!pressure)
			txFull <= 1'b0;
		else if (stretch == 0)
		begin
			txFull <= 1'($urandom_range(0, 1));
			stretch = $urandom_range(1, 40);
		end
		else
			stretch--;
	end

	////////////////////////////////////////
	// Checks and reply collection
	////////////////////////////////////////

	task automatic checkByte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			valueErrs++;
		end
	endtask

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			valueErrs++;
		end
	endtask

	task automatic takeByte(input string name, output logic [7:0] b);
		int waited;
		waited = 0;
		while (txQ.size() == 0 && waited < byteTimeout)
		begin
			@(negedge clk);
			waited++;
		end
		if (txQ.size() == 0)
		begin
			$display("Reply byte missing in %s", name);
			streamErrs++;
			b = 8'h00;
		end
		else
			b = txQ.pop_front();
	endtask

	// Four bytes, most significant first
	task automatic takeWord(input string name, output wordT w);
		logic [7:0] b;
		w = '0;
		for (int i = 0; i < 4; i++)
		begin
			takeByte(name, b);
			w = {w[debugPkg::wordWidth-9:0], b};
		end
	endtask

	////////////////////////////////////////
	// Commands
	////////////////////////////////////////

	task automatic writeWord(input int adr, input wordT data);
		logic [7:0] b;
		string name;
		name = $sformatf("write %0d", adr);
		@(negedge clk);
		rxQ.push_back(debugPkg::opWrite);
		rxQ.push_back(8'(adr));
		for (int i = 3; i >= 0; i--)
			rxQ.push_back(data[8*i +: 8]);
		takeByte(name, b);
		if (adr < numWords)
		begin
			model[adr] = data;
			checkByte(name, debugPkg::ackByte, b);
		end
		else
			checkByte(name, debugPkg::errByte, b);
	endtask

	task automatic readWord(input int adr);
		logic [7:0] b;
		wordT w;
		string name;
		name = $sformatf("read %0d", adr);
		@(negedge clk);
		rxQ.push_back(debugPkg::opRead);
		rxQ.push_back(8'(adr));
		if (adr < numWords)
		begin
			takeWord(name, w);
			checkWord(name, model[adr], w);
		end
		else
		begin
			takeByte(name, b);
			checkByte(name, debugPkg::errByte, b);
		end
	endtask

	task automatic dumpAll(input string name);
		wordT w;
		@(negedge clk);
		rxQ.push_back(debugPkg::opDump);
		for (int i = 0; i < numWords; i++)
		begin
			takeWord($sformatf("%s word %0d", name, i), w);
			checkWord($sformatf("%s word %0d", name, i), model[i], w);
		end
	endtask

	task automatic sendUnknown(input logic [7:0] op);
		logic [7:0] b;
		@(negedge clk);
		rxQ.push_back(op);
		takeByte($sformatf("opcode %h", op), b);
		checkByte($sformatf("opcode %h", op), debugPkg::errByte, b);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		int adrList [$];
		int adr;
		logic [7:0] op;
		clk = 1'b0;
		rstN = 1'b0;
		rxData = 8'h00;
		rxEmpty = 1'b1;
		txFull = 1'b0;
		pressure = 1'b0;
		stretch = 0;
		valueErrs = 0;
		streamErrs = 0;
		void'($urandom(32'h0aa25171));
		for (int i = 0; i < numWords; i++)
			model[i] = '0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		repeat (2) @(posedge clk);

		dumpAll("reset dump");

		// Random writes, then read back the same words
		for (int i = 0; i < writesA; i++)
		begin
			adr = $urandom_range(0, numWords - 1);
			adrList.push_back(adr);
			writeWord(adr, wordT'($urandom()));
		end
		foreach (adrList[i])
			readWord(adrList[i]);

		// Out of range, each followed by a good read to prove alignment
		for (int i = 0; i < badCount; i++)
		begin
			adr = $urandom_range(numWords, 255);
			if (i % 2 == 0)
				writeWord(adr, wordT'($urandom()));
			else
				readWord(adr);
			readWord($urandom_range(0, numWords - 1));
		end

		for (int i = 0; i < unknownCount; i++)
		begin
			do
				op = 8'($urandom());
			while (op == 8'h01 || op == 8'h02 || op == 8'h03);
			sendUnknown(op);
			readWord($urandom_range(0, numWords - 1));
		end

		// Transmit back-pressure for the last stretch
		@(negedge clk);
		pressure = 1'b1;
		for (int i = 0; i < lateWrites; i++)
			writeWord($urandom_range(0, numWords - 1), wordT'($urandom()));
		dumpAll("stalled dump");
		@(negedge clk);
		pressure = 1'b0;

		repeat (20) @(negedge clk);
		if (txQ.size() != 0)
		begin
			$display("%0d reply bytes arrived that no command asked for", txQ.size());
			streamErrs++;
		end
		if (rxQ.size() != 0)
		begin
			$display("%0d command bytes were never read", rxQ.size());
			streamErrs++;
		end

		$display("Errors: %0d value, %0d stream", valueErrs, streamErrs);
		if (valueErrs == 0 && streamErrs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog sized from the command count
	initial
	begin
		#(numCommands * 200 * 40);
		$display("Watchdog expired before all replies arrived");
		$display("Errors: %0d value, %0d stream", valueErrs, streamErrs);
		$display("Regression failed");
		$finish;
	end

endmodule
